// File: source/scm_pkg.sv
package scm_pkg;

    ////////////////////////////////////////
    // Array geometry
    ////////////////////////////////////////

    // Row address bits
    localparam int ADDR_WIDTH = 6;

    // Bits per stored word
    localparam int DATA_WIDTH = 32;

    // Number of ways, also width of the one-hot way select
    localparam int N_WAYS = 4;

    // Rows per way
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Row index into every way of the array
    typedef logic [ADDR_WIDTH-1:0] scm_addr_t;

    // One data word of a way
    typedef logic [DATA_WIDTH-1:0] scm_data_t;

    // One-hot way select
    // all zero means no way is touched
    typedef logic [N_WAYS-1:0] scm_way_t;

endpackage

// File: source/scm_req_if.sv
`timescale 1ns/1ps

interface scm_req_if;

    import scm_pkg::*;

    // Handshake
    // gnt is combinational from req, transfer at an edge with both high
    logic      req;
    logic      gnt;

    // Payload, held stable by the master until granted
    scm_addr_t add;
    scm_data_t wdata;
    scm_way_t  way;

    // Requester side
    modport master
    (
        output req, add, wdata, way,
        input  gnt
    );

    // Array or arbiter side
    modport slave
    (
        input  req, add, wdata, way,
        output gnt
    );

endinterface

// File: source/mux2_req_scm.sv
`timescale 1ns/1ps

module mux2_req_scm
(
    scm_req_if.slave  ch0_bus,
    scm_req_if.master out_bus,
    scm_req_if.slave  ch1_bus
);

    // Mux select, high picks channel 1
    logic sel;

    ////////////////////////////////////////
    // Fixed priority arbiter
    ////////////////////////////////////////

    // Outgoing request when either channel asks
    assign out_bus.req = ch0_bus.req | ch1_bus.req;

    // Channel 1 wins whenever it asks
    // flush and icache maintenance must not wait on refills
    assign sel = ch1_bus.req | ~ch0_bus.req;

    // Grant back to the winner only
    assign ch1_bus.gnt = ch1_bus.req & out_bus.gnt;
    assign ch0_bus.gnt = ch0_bus.req & ~ch1_bus.req & out_bus.gnt;

    ////////////////////////////////////////
    // Payload mux
    ////////////////////////////////////////

    always_comb
    begin : payload_mux
        if (sel)
        begin
            out_bus.add   = ch1_bus.add;
            out_bus.wdata = ch1_bus.wdata;
            out_bus.way   = ch1_bus.way;
        end
        else
        begin
            out_bus.add   = ch0_bus.add;
            out_bus.wdata = ch0_bus.wdata;
            out_bus.way   = ch0_bus.way;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Checked after the grant paths through the bank settle
    always_comb
    begin : grant_checks
        // Never both channels at once
        a_gnt_exclusive : assert final (!(ch0_bus.gnt && ch1_bus.gnt))
            else $error("mux2_req_scm: both channel grants high");

        // Grant only to a channel that asks
        a_gnt_to_req : assert final ((!ch0_bus.gnt || ch0_bus.req) &&
                                     (!ch1_bus.gnt || ch1_bus.req))
            else $error("mux2_req_scm: grant to an idle channel");
    end

endmodule

// File: source/scm_way_bank.sv
`timescale 1ns/1ps

module scm_way_bank
(
    input  logic               clk,
    input  logic               reset_i,

    scm_req_if.slave           wr_bus,

    input  logic               rd_req_i,
    input  scm_pkg::scm_addr_t rd_add_i,
    input  scm_pkg::scm_way_t  rd_way_i,
    output scm_pkg::scm_data_t rd_data_o,
    output logic               rd_valid_o
);

    import scm_pkg::*;

    // Storage, one word per row per way
    scm_data_t mem [DEPTH][N_WAYS];

    // Word picked for the current read
    scm_data_t rd_word;

    // Write accepted at this edge
    logic      wr_fire;

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    // Single port, so a read takes the cycle and the write waits
    assign wr_bus.gnt = wr_bus.req & ~rd_req_i;

    assign wr_fire = wr_bus.req & wr_bus.gnt;

    // Every selected way takes the word
    // a zero way select leaves the row as it was
    always_ff @(posedge clk)
    begin : write_array
        if (wr_fire)
        begin
            for (int w = 0; w < N_WAYS; w++)
            begin
                if (wr_bus.way[w])
                begin
                    mem[wr_bus.add][w] <= wr_bus.wdata;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Lowest set bit of the way select wins
    always_comb
    begin : read_select
        logic found;
        found   = 1'b0;
        rd_word = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (rd_way_i[w] && !found)
            begin
                rd_word = mem[rd_add_i][w];
                found   = 1'b1;
            end
        end
    end

    // Read data register, only loaded on a read
    always_ff @(posedge clk)
    begin : read_data_reg
        if (rd_req_i)
        begin
            rd_data_o <= rd_word;
        end
    end

    // Valid flag, one cycle behind the request
    always_ff @(posedge clk)
    begin : read_valid_reg
        if (reset_i)
        begin
            rd_valid_o <= 1'b0;
        end
        else
        begin
            rd_valid_o <= rd_req_i;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Granted writes touch at most one way
    a_wr_way_onehot0 : assert property (@(posedge clk) disable iff (reset_i)
        wr_fire |-> $onehot0(wr_bus.way))
        else $error("scm_way_bank: write way select not one-hot or zero");

    // A read names exactly one way
    a_rd_way_onehot : assert property (@(posedge clk) disable iff (reset_i)
        rd_req_i |-> $onehot(rd_way_i))
        else $error("scm_way_bank: read way select not one-hot");

endmodule

// File: source/scm_write_path_top.sv
`timescale 1ns/1ps

module scm_write_path_top
(
    input  logic               clk,
    input  logic               reset_i,

    // Channel 0, refill writes
    input  logic               ch0_req_i,
    input  scm_pkg::scm_addr_t ch0_add_i,
    input  scm_pkg::scm_data_t ch0_wdata_i,
    input  scm_pkg::scm_way_t  ch0_way_i,
    output logic               ch0_gnt_o,

    // Channel 1, flush and icache maintenance writes
    input  logic               ch1_req_i,
    input  scm_pkg::scm_addr_t ch1_add_i,
    input  scm_pkg::scm_data_t ch1_wdata_i,
    input  scm_pkg::scm_way_t  ch1_way_i,
    output logic               ch1_gnt_o,

    // Read port, has priority over both channels
    input  logic               rd_req_i,
    input  scm_pkg::scm_addr_t rd_add_i,
    input  scm_pkg::scm_way_t  rd_way_i,
    output scm_pkg::scm_data_t rd_data_o,
    output logic               rd_valid_o
);

    ////////////////////////////////////////
    // Request buses
    ////////////////////////////////////////

    scm_req_if ch0_bus ();
    scm_req_if ch1_bus ();

    // Arbiter to array
    scm_req_if bank_bus ();

    // Channel 0 master side from pins
    assign ch0_bus.req   = ch0_req_i;
    assign ch0_bus.add   = ch0_add_i;
    assign ch0_bus.wdata = ch0_wdata_i;
    assign ch0_bus.way   = ch0_way_i;
    assign ch0_gnt_o     = ch0_bus.gnt;

    // Channel 1 master side from pins
    assign ch1_bus.req   = ch1_req_i;
    assign ch1_bus.add   = ch1_add_i;
    assign ch1_bus.wdata = ch1_wdata_i;
    assign ch1_bus.way   = ch1_way_i;
    assign ch1_gnt_o     = ch1_bus.gnt;

    ////////////////////////////////////////
    // Arbiter and mux
    ////////////////////////////////////////

    // Channel 1 beats channel 0
    mux2_req_scm u_mux
    (
        .ch0_bus (ch0_bus),
        .out_bus (bank_bus),
        .ch1_bus (ch1_bus)
    );

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Read request pulls the write grant low
    scm_way_bank u_bank
    (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_bus     (bank_bus),
        .rd_req_i   (rd_req_i),
        .rd_add_i   (rd_add_i),
        .rd_way_i   (rd_way_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o)
    );

endmodule

// File: testbench/scm_write_path_tb.sv
`timescale 1ns/1ps

module scm_write_path_tb;

    import scm_pkg::*;

    ////////////////////////////////////////
    // Run setup
    ////////////////////////////////////////

    localparam int    CLK_HALF        = 20;
    localparam int    RESET_CYCLES    = 8;
    localparam int    CYCLES_PER_TEST = 10;
    localparam int    RANDOM_SEED     = 57;
    localparam string TEST_FILE       = "testbench/scm_tests.txt";

    // One clock cycle of stimulus and its expected response
    typedef struct packed
    {
        logic       ch0_req;
        scm_addr_t  ch0_add;
        scm_data_t  ch0_wdata;
        scm_way_t   ch0_way;
        logic       ch1_req;
        scm_addr_t  ch1_add;
        scm_data_t  ch1_wdata;
        scm_way_t   ch1_way;
        logic       rd_req;
        scm_addr_t  rd_add;
        scm_way_t   rd_way;
        logic [1:0] rnd;
        logic       exp_ch0_gnt;
        logic       exp_ch1_gnt;
        logic       rd_from_model;
        scm_data_t  exp_rd_data;
    } test_vec_t;

    logic      clk;
    logic      reset_i;
    logic      ch0_req_i;
    scm_addr_t ch0_add_i;
    scm_data_t ch0_wdata_i;
    scm_way_t  ch0_way_i;
    logic      ch0_gnt_o;
    logic      ch1_req_i;
    scm_addr_t ch1_add_i;
    scm_data_t ch1_wdata_i;
    scm_way_t  ch1_way_i;
    logic      ch1_gnt_o;
    logic      rd_req_i;
    scm_addr_t rd_add_i;
    scm_way_t  rd_way_i;
    scm_data_t rd_data_o;
    logic      rd_valid_o;

    test_vec_t tests [$];

    // Reference array, key is row times N_WAYS plus way
    scm_data_t model [int];

    int        error_count = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    logic      test_failed = 1'b0;
    logic      tests_loaded = 1'b0;

    // Read result due at the next edge
    scm_data_t rd_expect;
    logic      rd_expect_known;

    // Random payload kept while its channel waits for a grant
    logic      ch0_waiting = 1'b0;
    logic      ch1_waiting = 1'b0;
    scm_data_t ch0_rnd_data;
    scm_data_t ch1_rnd_data;
    scm_data_t ch0_sent;
    scm_data_t ch1_sent;

    scm_write_path_top UUT
    (
        .clk         (clk),
        .reset_i     (reset_i),
        .ch0_req_i   (ch0_req_i),
        .ch0_add_i   (ch0_add_i),
        .ch0_wdata_i (ch0_wdata_i),
        .ch0_way_i   (ch0_way_i),
        .ch0_gnt_o   (ch0_gnt_o),
        .ch1_req_i   (ch1_req_i),
        .ch1_add_i   (ch1_add_i),
        .ch1_wdata_i (ch1_wdata_i),
        .ch1_way_i   (ch1_way_i),
        .ch1_gnt_o   (ch1_gnt_o),
        .rd_req_i    (rd_req_i),
        .rd_add_i    (rd_add_i),
        .rd_way_i    (rd_way_i),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o)
    );

    initial clk = 1'b0;

    always
    begin
        #(CLK_HALF) clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic int slot(input scm_addr_t add, input int w);
        return int'(add) * N_WAYS + w;
    endfunction

    // Lowest set way bit, -1 for an empty select
    function automatic int lowest_way(input scm_way_t way);
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way[w])
            begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        test_vec_t   t;
        logic [31:0] c0r, c0a, c0d, c0w;
        logic [31:0] c1r, c1a, c1d, c1w;
        logic [31:0] rr, ra, rw, rnd;
        logic [31:0] eg0, eg1, src, erd;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the test file %s", TEST_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c0r, c0a, c0d, c0w, c1r, c1a, c1d, c1w,
                        rr, ra, rw, rnd, eg0, eg1, src, erd);
            if (n == 16)
            begin
                t.ch0_req       = c0r[0];
                t.ch0_add       = c0a[ADDR_WIDTH-1:0];
                t.ch0_wdata     = c0d;
                t.ch0_way       = c0w[N_WAYS-1:0];
                t.ch1_req       = c1r[0];
                t.ch1_add       = c1a[ADDR_WIDTH-1:0];
                t.ch1_wdata     = c1d;
                t.ch1_way       = c1w[N_WAYS-1:0];
                t.rd_req        = rr[0];
                t.rd_add        = ra[ADDR_WIDTH-1:0];
                t.rd_way        = rw[N_WAYS-1:0];
                t.rnd           = rnd[1:0];
                t.exp_ch0_gnt   = eg0[0];
                t.exp_ch1_gnt   = eg1[0];
                t.rd_from_model = src[0];
                t.exp_rd_data   = erd;
                tests.push_back(t);
            end
            else if (n > 0)
            begin
                $display("Malformed line in the test file: %s", line);
                error_count++;
            end
        end
        $fclose(fd);
        if (tests.size() == 0)
        begin
            $display("No tests were loaded from %s", TEST_FILE);
            error_count++;
        end
    endtask

    // Inputs change only just after a rising edge
    task automatic drive_test(input test_vec_t t);
        ch0_sent = t.ch0_wdata;
        ch1_sent = t.ch1_wdata;
        // New random word only when the previous request was granted
        if (t.rnd[0])
        begin
            if (!ch0_waiting)
            begin
                ch0_rnd_data = $urandom;
            end
            ch0_sent = ch0_rnd_data;
        end
        if (t.rnd[1])
        begin
            if (!ch1_waiting)
            begin
                ch1_rnd_data = $urandom;
            end
            ch1_sent = ch1_rnd_data;
        end
        ch0_req_i   <= t.ch0_req;
        ch0_add_i   <= t.ch0_add;
        ch0_wdata_i <= ch0_sent;
        ch0_way_i   <= t.ch0_way;
        ch1_req_i   <= t.ch1_req;
        ch1_add_i   <= t.ch1_add;
        ch1_wdata_i <= ch1_sent;
        ch1_way_i   <= t.ch1_way;
        rd_req_i    <= t.rd_req;
        rd_add_i    <= t.rd_add;
        rd_way_i    <= t.rd_way;
    endtask

    task automatic check_idle(input string phase);
        assert (rd_valid_o === 1'b0)
        else
        begin
            $display("** Error: %s rd_valid_o expected 0 got %h", phase, rd_valid_o);
            error_count++;
        end
        assert (ch0_gnt_o === 1'b0 && ch1_gnt_o === 1'b0)
        else
        begin
            $display("** Error: %s ch0_gnt_o/ch1_gnt_o expected 0/0 got %h/%h",
                     phase, ch0_gnt_o, ch1_gnt_o);
            error_count++;
        end
    endtask

    task automatic check_grants(input int idx, input test_vec_t t);
        assert (ch0_gnt_o === t.exp_ch0_gnt)
        else
        begin
            $display("** Error: test %0d ch0_gnt_o expected %h got %h",
                     idx, t.exp_ch0_gnt, ch0_gnt_o);
            error_count++;
            test_failed = 1'b1;
        end
        assert (ch1_gnt_o === t.exp_ch1_gnt)
        else
        begin
            $display("** Error: test %0d ch1_gnt_o expected %h got %h",
                     idx, t.exp_ch1_gnt, ch1_gnt_o);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    // Row contents before the coming edge
    task automatic expect_read(input test_vec_t t);
        int w;
        w = lowest_way(t.rd_way);
        rd_expect_known = 1'b1;
        rd_expect       = t.exp_rd_data;
        if (t.rd_from_model)
        begin
            if (w >= 0 && model.exists(slot(t.rd_add, w)))
            begin
                rd_expect = model[slot(t.rd_add, w)];
            end
            else
            begin
                rd_expect_known = 1'b0;
            end
        end
    endtask

    // Winner writes every selected way at the coming edge
    task automatic mirror_writes(input test_vec_t t);
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (t.exp_ch1_gnt && t.ch1_way[w])
            begin
                model[slot(t.ch1_add, w)] = ch1_sent;
            end
            else if (t.exp_ch0_gnt && t.ch0_way[w])
            begin
                model[slot(t.ch0_add, w)] = ch0_sent;
            end
        end
        ch0_waiting = t.ch0_req && !t.exp_ch0_gnt;
        ch1_waiting = t.ch1_req && !t.exp_ch1_gnt;
    endtask

    // Read of test idx answers one edge later
    task automatic check_read(input int idx);
        if (tests[idx].rd_req)
        begin
            assert (rd_valid_o === 1'b1)
            else
            begin
                $display("test %0d: rd_valid_o did not rise one cycle after the read", idx);
                error_count++;
                test_failed = 1'b1;
            end
            assert (rd_expect_known)
            else
            begin
                $display("test %0d: no reference word for the read of row %h", idx,
                         tests[idx].rd_add);
                error_count++;
                test_failed = 1'b1;
            end
            if (rd_expect_known)
            begin
                assert (rd_data_o === rd_expect)
                else
                begin
                    $display("** Error: test %0d rd_data_o expected %h got %h",
                             idx, rd_expect, rd_data_o);
                    error_count++;
                    test_failed = 1'b1;
                end
            end
        end
        else
        begin
            assert (rd_valid_o === 1'b0)
            else
            begin
                $display("** Error: test %0d rd_valid_o expected 0 got %h",
                         idx, rd_valid_o);
                error_count++;
                test_failed = 1'b1;
            end
        end
    endtask

    task automatic report_test(input int idx);
        if (test_failed)
        begin
            fail_count++;
            $display("test %0d: failed", idx);
        end
        else
        begin
            pass_count++;
            $display("test %0d: ok", idx);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin : main
        void'($urandom(RANDOM_SEED));
        reset_i     <= 1'b1;
        ch0_req_i   <= 1'b0;
        ch0_add_i   <= '0;
        ch0_wdata_i <= '0;
        ch0_way_i   <= '0;
        ch1_req_i   <= 1'b0;
        ch1_add_i   <= '0;
        ch1_wdata_i <= '0;
        ch1_way_i   <= '0;
        // Read held through reset, valid must still stay low
        rd_req_i    <= 1'b1;
        rd_add_i    <= '0;
        rd_way_i    <= scm_way_t'(1);
        load_tests();
        tests_loaded = 1'b1;

        // Reset seen at 8 rising edges
        repeat (RESET_CYCLES - 1)
        begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        reset_i  <= 1'b0;
        rd_req_i <= 1'b0;
        rd_way_i <= '0;
        @(negedge clk);
        check_idle("after reset");

        // One line per cycle, plus one idle cycle for the last read
        for (int i = 0; i <= tests.size(); i++)
        begin
            @(posedge clk);
            if (i < tests.size())
            begin
                drive_test(tests[i]);
            end
            else
            begin
                drive_test('0);
            end
            @(negedge clk);
            if (i > 0)
            begin
                check_read(i - 1);
                report_test(i - 1);
            end
            if (i < tests.size())
            begin
                test_failed = 1'b0;
                check_grants(i, tests[i]);
                expect_read(tests[i]);
                mirror_writes(tests[i]);
            end
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Limit scales with the number of loaded tests
    initial
    begin : watchdog
        longint limit_ns;
        wait (tests_loaded);
        limit_ns = (longint'(tests.size() + 1) * CYCLES_PER_TEST + RESET_CYCLES)
                   * 2 * CLK_HALF;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: testbench/scm_tests.txt
# ch0: req add wdata way | ch1: req add wdata way | rd: req add way | rnd (bit0 ch0, bit1 ch1)
# expected: ch0_gnt ch1_gnt | rd source (0 this line, 1 reference model) rd_data; all hex
# Reset state, nothing requested
0 00 00000000 0 0 00 00000000 0 0 00 0 0 0 0 0 00000000
0 00 00000000 0 0 00 00000000 0 0 00 0 0 0 0 0 00000000
# Channel 0 alone, then read back
1 05 a5a50001 1 0 00 00000000 0 0 00 0 0 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 05 1 0 0 0 0 a5a50001
# Channel 1 alone, then read back
0 00 00000000 0 1 0a 5a5a0002 2 0 00 0 0 0 1 0 00000000
0 00 00000000 0 0 00 00000000 0 1 0a 2 0 0 0 0 5a5a0002
# Contention, channel 1 first, channel 0 the cycle after
1 10 11110000 4 1 11 22220000 8 0 00 0 0 0 1 0 00000000
1 10 11110000 4 0 00 00000000 0 0 00 0 0 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 10 4 0 0 0 0 11110000
0 00 00000000 0 0 00 00000000 0 1 11 8 0 0 0 0 22220000
# Channel 0 held off by two channel 1 writes in a row
1 12 33330000 1 1 13 44440000 1 0 00 0 0 0 1 0 00000000
1 12 33330000 1 1 14 55550000 2 0 00 0 0 0 1 0 00000000
1 12 33330000 1 0 00 00000000 0 0 00 0 0 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 12 1 0 0 0 0 33330000
0 00 00000000 0 0 00 00000000 0 1 13 1 0 0 0 0 44440000
0 00 00000000 0 0 00 00000000 0 1 14 2 0 0 0 0 55550000
# Read priority, a two cycle read stalls both channels and sees the old word
1 20 66660000 1 0 00 00000000 0 0 00 0 0 1 0 0 00000000
1 20 77770000 1 1 21 88880000 1 1 20 1 0 0 0 0 66660000
1 20 77770000 1 1 21 88880000 1 1 20 1 0 0 0 0 66660000
1 20 77770000 1 1 21 88880000 1 0 00 0 0 0 1 0 00000000
1 20 77770000 1 0 00 00000000 0 0 00 0 0 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 20 1 0 0 0 0 77770000
0 00 00000000 0 0 00 00000000 0 1 21 1 0 0 0 0 88880000
# Fill writes with random data, read back against the reference model
1 30 00000000 1 0 00 00000000 0 0 00 0 1 1 0 0 00000000
0 00 00000000 0 1 31 00000000 2 0 00 0 2 0 1 0 00000000
1 32 00000000 4 1 33 00000000 8 0 00 0 3 0 1 0 00000000
1 32 00000000 4 0 00 00000000 0 0 00 0 1 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 30 1 0 0 0 1 00000000
0 00 00000000 0 0 00 00000000 0 1 31 2 0 0 0 1 00000000
0 00 00000000 0 0 00 00000000 0 1 32 4 0 0 0 1 00000000
0 00 00000000 0 0 00 00000000 0 1 33 8 0 0 0 1 00000000
# Way isolation on row 3c, one way rewritten, then a zero way select
0 00 00000000 0 1 3c aaaa0001 1 0 00 0 0 0 1 0 00000000
0 00 00000000 0 1 3c aaaa0002 2 0 00 0 0 0 1 0 00000000
0 00 00000000 0 1 3c aaaa0004 4 0 00 0 0 0 1 0 00000000
0 00 00000000 0 1 3c aaaa0008 8 0 00 0 0 0 1 0 00000000
1 3c bbbb0004 4 0 00 00000000 0 0 00 0 0 1 0 0 00000000
1 3c cccc0000 0 0 00 00000000 0 0 00 0 0 1 0 0 00000000
0 00 00000000 0 0 00 00000000 0 1 3c 1 0 0 0 0 aaaa0001
0 00 00000000 0 0 00 00000000 0 1 3c 2 0 0 0 0 aaaa0002
0 00 00000000 0 0 00 00000000 0 1 3c 4 0 0 0 0 bbbb0004
0 00 00000000 0 0 00 00000000 0 1 3c 8 0 0 0 0 aaaa0008
# Back to idle, grants low and no valid
0 00 00000000 0 0 00 00000000 0 0 00 0 0 0 0 0 00000000

// File: files.f
source/scm_pkg.sv
source/scm_req_if.sv
source/mux2_req_scm.sv
source/scm_way_bank.sv
source/scm_write_path_top.sv
testbench/scm_write_path_tb.sv

// File: Makefile
# Verilator flow for the SCM write path, run from the project root

VERILATOR  ?= verilator
TOP        ?= scm_write_path_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line also counts as failure
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
